/* flash_address_seq.sv */
`timescale 1ns/1ns
`default_nettype none

module flash_address_seq #(
  parameter ipod_pkg::flash_addr_t LAST_ADDR = 23'h7FFFF
) (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic                  dir,
  input  logic                  restart,
  input  logic                  word_req,
  output logic                  rd_req,
  output ipod_pkg::flash_addr_t rd_addr
);
  import ipod_pkg::*;

  flash_addr_t next_addr;

  // One word in the current direction, wrapping at both song ends
  always_comb
  begin
    if (dir)
      next_addr = (rd_addr == '0) ? LAST_ADDR : rd_addr - 1'b1;
    else
      next_addr = (rd_addr == LAST_ADDR) ? '0 : rd_addr + 1'b1;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      rd_addr <= '0;
      rd_req  <= 1'b0;
    end
    else
    begin
      rd_req <= 1'b0;
      // Restart wins over a word request in the same cycle
      if (restart)
      begin
        rd_addr <= dir ? LAST_ADDR : '0;
        rd_req  <= 1'b1;
      end
      else if (word_req)
      begin
        rd_addr <= next_addr;
        rd_req  <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* flash_read_port.sv */
`timescale 1ns/1ns
`default_nettype none

module flash_read_port (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic                  rd_req,
  input  ipod_pkg::flash_addr_t rd_addr,
  output ipod_pkg::flash_word_t rd_data,
  output logic                  rd_valid,
  output logic                  flash_read,
  output ipod_pkg::flash_addr_t flash_address,
  input  logic                  flash_waitrequest,
  input  ipod_pkg::flash_word_t flash_readdata,
  input  logic                  flash_readdatavalid
);
  import ipod_pkg::*;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_REQ  = 2'd1;
  localparam logic [1:0] ST_DATA = 2'd2;

  logic [1:0]  state;
  logic        pend;
  flash_addr_t pend_addr;

  assign flash_read = (state == ST_REQ);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      pend     <= 1'b0;
      rd_valid <= 1'b0;
    end
    else
    begin
      rd_valid <= 1'b0;
      // Park requests that arrive while busy
      if (rd_req && state != ST_IDLE)
        pend <= 1'b1;
      case (state)
        ST_IDLE:
          if (rd_req)
            state <= ST_REQ;
        ST_REQ:
          if (!flash_waitrequest)
            state <= ST_DATA;
        ST_DATA:
          if (flash_readdatavalid)
          begin
            rd_valid <= 1'b1;
            pend     <= 1'b0;
            state    <= (pend || rd_req) ? ST_REQ : ST_IDLE;
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Address and returned word
  always_ff @(posedge CLK_50M)
  begin
    if (rd_req && state != ST_IDLE)
      pend_addr <= rd_addr;
    if (state == ST_IDLE && rd_req)
      flash_address <= rd_addr;
    else if (state == ST_DATA && flash_readdatavalid)
      flash_address <= rd_req ? rd_addr : pend_addr;
    if (state == ST_DATA && flash_readdatavalid)
      rd_data <= flash_readdata;
  end

endmodule

`default_nettype wire

/* ipod_pkg.sv */
`default_nettype none

package ipod_pkg;

  localparam int FLASH_ADDR_W = 23;
  localparam int SAMPLE_W = 16;

  typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;
  // Two samples packed per flash word
  typedef logic [2*SAMPLE_W-1:0] flash_word_t;
  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic [15:0] div_t;
  typedef logic [7:0] ascii_t;

  // Keyboard command codes in both cases
  localparam ascii_t ASCII_E_UP = 8'h45;
  localparam ascii_t ASCII_E_LO = 8'h65;
  localparam ascii_t ASCII_D_UP = 8'h44;
  localparam ascii_t ASCII_D_LO = 8'h64;
  localparam ascii_t ASCII_F_UP = 8'h46;
  localparam ascii_t ASCII_F_LO = 8'h66;
  localparam ascii_t ASCII_B_UP = 8'h42;
  localparam ascii_t ASCII_B_LO = 8'h62;
  localparam ascii_t ASCII_R_UP = 8'h52;
  localparam ascii_t ASCII_R_LO = 8'h72;

endpackage

`default_nettype wire

/* ipod_player.sv */
`timescale 1ns/1ns
`default_nettype none

module ipod_player #(
  parameter ipod_pkg::div_t       DEFAULT_DIV = 16'd1136,
  parameter ipod_pkg::div_t       SPEED_STEP  = 16'd100,
  parameter ipod_pkg::div_t       MIN_DIV     = 16'd200,
  parameter ipod_pkg::div_t       MAX_DIV     = 16'd5000,
  parameter ipod_pkg::flash_addr_t LAST_ADDR  = 23'h7FFFF
) (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  ipod_pkg::ascii_t      ascii_code,
  input  logic                  ascii_valid,
  input  logic                  speed_up,
  input  logic                  speed_down,
  input  logic                  speed_reset,
  input  logic                  flash_waitrequest,
  input  ipod_pkg::flash_word_t flash_readdata,
  input  logic                  flash_readdatavalid,
  output logic                  flash_read,
  output ipod_pkg::flash_addr_t flash_address,
  output ipod_pkg::sample_t     sample,
  output logic                  sample_valid
);
  import ipod_pkg::*;

  logic        play;
  logic        dir;
  logic        restart;
  logic        tick;
  logic        word_req;
  logic        rd_req;
  flash_addr_t rd_addr;
  flash_word_t rd_data;
  logic        rd_valid;

  // ====================
  // Control
  player_command player_command_i (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .ascii_code  (ascii_code),
    .ascii_valid (ascii_valid),
    .play        (play),
    .dir         (dir),
    .restart     (restart)
  );

  sample_rate_gen #(
    .DEFAULT_DIV (DEFAULT_DIV),
    .SPEED_STEP  (SPEED_STEP),
    .MIN_DIV     (MIN_DIV),
    .MAX_DIV     (MAX_DIV)
  ) sample_rate_gen_i (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .play        (play),
    .restart     (restart),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .tick        (tick)
  );

  // ====================
  // Flash fetch and sample output
  flash_address_seq #(
    .LAST_ADDR (LAST_ADDR)
  ) flash_address_seq_i (
    .CLK_50M  (CLK_50M),
    .rst_n    (rst_n),
    .dir      (dir),
    .restart  (restart),
    .word_req (word_req),
    .rd_req   (rd_req),
    .rd_addr  (rd_addr)
  );

  flash_read_port flash_read_port_i (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .rd_req              (rd_req),
    .rd_addr             (rd_addr),
    .rd_data             (rd_data),
    .rd_valid            (rd_valid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  sample_unpack sample_unpack_i (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .tick         (tick),
    .dir          (dir),
    .restart      (restart),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid),
    .word_req     (word_req),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

endmodule

`default_nettype wire

/* ipod_player_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module ipod_player_sva (
  input logic                  CLK_50M,
  input logic                  rst_n,
  input logic                  flash_read,
  input ipod_pkg::flash_addr_t flash_address,
  input logic                  flash_waitrequest,
  input logic                  sample_valid
);

  // Request held until waitrequest drops
  a_read_held: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address)
  ) else $error("flash_read or flash_address changed under waitrequest");

  // One cycle per sample
  a_sample_pulse: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    sample_valid |=> !sample_valid
  ) else $error("sample_valid high for two cycles in a row");

  // Outputs idle while reset is held
  a_reset_idle: assert property (
    @(posedge CLK_50M)
    !rst_n |=> !flash_read && !sample_valid
  ) else $error("flash_read or sample_valid active during reset");

endmodule

bind ipod_player ipod_player_sva ipod_player_sva_i (.*);

`default_nettype wire

/* player_command.sv */
`timescale 1ns/1ns
`default_nettype none

module player_command (
  input  logic             CLK_50M,
  input  logic             rst_n,
  input  ipod_pkg::ascii_t ascii_code,
  input  logic             ascii_valid,
  output logic             play,
  output logic             dir,
  output logic             restart
);
  import ipod_pkg::*;

  logic is_play;
  logic is_pause;
  logic is_fwd;
  logic is_bwd;
  logic is_restart;

  assign is_play    = (ascii_code == ASCII_E_UP) || (ascii_code == ASCII_E_LO);
  assign is_pause   = (ascii_code == ASCII_D_UP) || (ascii_code == ASCII_D_LO);
  assign is_fwd     = (ascii_code == ASCII_F_UP) || (ascii_code == ASCII_F_LO);
  assign is_bwd     = (ascii_code == ASCII_B_UP) || (ascii_code == ASCII_B_LO);
  assign is_restart = (ascii_code == ASCII_R_UP) || (ascii_code == ASCII_R_LO);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      play    <= 1'b0;
      dir     <= 1'b0;
      restart <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (ascii_valid)
      begin
        // Starting from stopped rewinds to the start address
        if (is_play)
        begin
          play    <= 1'b1;
          restart <= !play;
        end
        if (is_pause)
          play <= 1'b0;
        if (is_fwd)
          dir <= 1'b0;
        if (is_bwd)
          dir <= 1'b1;
        if (is_restart)
          restart <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Compile and run the ipod_player testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
  --top-module tb_ipod_player \
  -f tb.f \
  -o sim_ipod_player
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_ipod_player
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

/* sample_rate_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_rate_gen #(
  parameter ipod_pkg::div_t DEFAULT_DIV = 16'd1136,
  parameter ipod_pkg::div_t SPEED_STEP  = 16'd100,
  parameter ipod_pkg::div_t MIN_DIV     = 16'd200,
  parameter ipod_pkg::div_t MAX_DIV     = 16'd5000
) (
  input  logic CLK_50M,
  input  logic rst_n,
  input  logic play,
  input  logic restart,
  input  logic speed_up,
  input  logic speed_down,
  input  logic speed_reset,
  output logic tick
);
  import ipod_pkg::*;

  div_t div;
  div_t count;
  logic play_d;
  logic load;

  assign load = restart || (play && !play_d);

  // ====================
  // Divisor with clamped steps
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n || speed_reset)
      div <= DEFAULT_DIV;
    else if (speed_up)
      div <= (div < MIN_DIV + SPEED_STEP) ? MIN_DIV : div - SPEED_STEP;
    else if (speed_down)
      div <= (div > MAX_DIV - SPEED_STEP) ? MAX_DIV : div + SPEED_STEP;
  end

  // ====================
  // Tick counter reloads at each tick so a new divisor applies from there
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      count  <= DEFAULT_DIV;
      play_d <= 1'b0;
      tick   <= 1'b0;
    end
    else
    begin
      play_d <= play;
      tick   <= 1'b0;
      if (load)
        count <= div;
      else if (play)
      begin
        if (count <= 16'd1)
        begin
          tick  <= 1'b1;
          count <= div;
        end
        else
          count <= count - 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* sample_unpack.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_unpack (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic                  tick,
  input  logic                  dir,
  input  logic                  restart,
  input  ipod_pkg::flash_word_t rd_data,
  input  logic                  rd_valid,
  output logic                  word_req,
  output ipod_pkg::sample_t     sample,
  output logic                  sample_valid
);
  import ipod_pkg::*;

  flash_word_t cur_word;
  flash_word_t nxt_word;
  logic        cur_valid;
  logic        nxt_valid;
  logic        cur_rev;
  logic        half;
  logic        live_rd;
  logic        stale_rd;
  logic        accept;
  logic        consume;
  logic        last_half;
  logic        cur_free;
  sample_t     hi_half;
  sample_t     lo_half;

  assign hi_half   = cur_word[2*SAMPLE_W-1:SAMPLE_W];
  assign lo_half   = cur_word[SAMPLE_W-1:0];
  // Words from reads issued before a restart are dropped
  assign accept    = rd_valid && !stale_rd;
  assign consume   = tick && cur_valid;
  assign last_half = consume && half;
  assign cur_free  = !cur_valid || (last_half && !nxt_valid);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      cur_valid    <= 1'b0;
      nxt_valid    <= 1'b0;
      cur_rev      <= 1'b0;
      half         <= 1'b0;
      live_rd      <= 1'b0;
      stale_rd     <= 1'b0;
      word_req     <= 1'b0;
      sample_valid <= 1'b0;
    end
    else if (restart)
    begin
      cur_valid    <= 1'b0;
      nxt_valid    <= 1'b0;
      half         <= 1'b0;
      word_req     <= 1'b0;
      sample_valid <= 1'b0;
      live_rd      <= 1'b1;
      stale_rd     <= (live_rd && stale_rd) || ((live_rd || stale_rd) && !rd_valid);
    end
    else
    begin
      sample_valid <= consume;
      word_req     <= 1'b0;
      if (consume)
        half <= !half;
      if (rd_valid && stale_rd)
        stale_rd <= 1'b0;
      else if (rd_valid)
        live_rd <= 1'b0;
      // A request without restart makes the address stage issue a read
      if (word_req)
        live_rd <= 1'b1;
      if (accept && cur_free)
      begin
        cur_valid <= 1'b1;
        cur_rev   <= dir;
        word_req  <= 1'b1;
      end
      else if (last_half && nxt_valid)
      begin
        cur_rev   <= dir;
        nxt_valid <= 1'b0;
        word_req  <= 1'b1;
      end
      else if (last_half)
        cur_valid <= 1'b0;
      if (accept && !cur_free)
        nxt_valid <= 1'b1;
    end
  end

  // Backward words play high half first
  always_ff @(posedge CLK_50M)
  begin
    if (accept && cur_free)
      cur_word <= rd_data;
    else if (last_half && nxt_valid)
      cur_word <= nxt_word;
    if (accept && !cur_free)
      nxt_word <= rd_data;
    if (consume)
      sample <= (half ^ cur_rev) ? hi_half : lo_half;
  end

endmodule

`default_nettype wire

/* tb.f */
ipod_pkg.sv
player_command.sv
sample_rate_gen.sv
flash_address_seq.sv
flash_read_port.sv
sample_unpack.sv
ipod_player.sv
ipod_player_sva.sv
tb_ipod_player.sv

/* tb_ipod_player.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_ipod_player;
  import ipod_pkg::*;

  localparam div_t        DEFAULT_DIV    = 16'd40;
  localparam div_t        SPEED_STEP     = 16'd8;
  localparam div_t        MIN_DIV        = 16'd24;
  localparam div_t        MAX_DIV        = 16'd64;
  localparam flash_addr_t LAST_ADDR      = 23'd7;
  localparam logic [31:0] LFSR_SEED      = 32'ha93aaac9;
  localparam int          IDLE_CYCLES    = 200;
  localparam int          SAMPLE_TIMEOUT = 4 * 64 + 64;

  // Step kinds
  localparam logic [1:0] K_KEY  = 2'd0;
  localparam logic [1:0] K_UP   = 2'd1;
  localparam logic [1:0] K_DOWN = 2'd2;
  localparam logic [1:0] K_SRST = 2'd3;

  typedef struct packed {
    logic [1:0] kind;
    ascii_t     code;
    logic [7:0] n;
    div_t       div;
    logic [7:0] quiet;
  } step_t;

  logic        CLK_50M;
  logic        rst_n;
  ascii_t      ascii_code;
  logic        ascii_valid;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  logic        flash_waitrequest;
  flash_word_t flash_readdata;
  logic        flash_readdatavalid;
  logic        flash_read;
  flash_addr_t flash_address;
  sample_t     sample;
  logic        sample_valid;

  logic [31:0] lfsr;
  step_t       steps[$];
  int          cyc;
  logic        got_sample;
  logic        expect_quiet;
  logic        ref_play;
  logic        ref_dir;
  // Reference position in the song
  flash_addr_t m_addr;
  logic        m_half;
  logic        m_rev;

  ipod_player #(
    .DEFAULT_DIV (DEFAULT_DIV),
    .SPEED_STEP  (SPEED_STEP),
    .MIN_DIV     (MIN_DIV),
    .MAX_DIV     (MAX_DIV),
    .LAST_ADDR   (LAST_ADDR)
  ) ipod_player_i (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .ascii_code          (ascii_code),
    .ascii_valid         (ascii_valid),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .sample              (sample),
    .sample_valid        (sample_valid)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever
      #10 CLK_50M = ~CLK_50M;
  end

  // ====================
  // Random counts and flash contents
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    // Taps 32, 22, 2, 1
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [3:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr = next_lfsr(lfsr);
      v    = {v[2:0], lfsr[0]};
    end
  endtask

  function automatic flash_word_t flash_word(input flash_addr_t a);
    // Low half holds the address and high half its inverse mixed with the top bits
    return {~a[15:0] ^ {9'd0, a[22:16]}, a[15:0]};
  endfunction

  // Flash slave with random waitrequest and read latency
  initial
  begin : flash_model
    int          fstate;
    int          wleft;
    int          lat;
    logic [3:0]  r;
    flash_addr_t acc_addr;
    flash_waitrequest   = 1'b1;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
    lfsr     = LFSR_SEED;
    fstate   = 0;
    wleft    = 0;
    lat      = 0;
    acc_addr = '0;
    forever
    begin
      @(negedge CLK_50M);
      flash_readdatavalid = 1'b0;
      flash_waitrequest   = 1'b1;
      if (fstate == 2)
      begin
        if (lat == 1)
        begin
          flash_readdata      = flash_word(acc_addr);
          flash_readdatavalid = 1'b1;
          fstate              = 0;
        end
        else
          lat = lat - 1;
      end
      else
      begin
        if (fstate == 0 && flash_read)
        begin
          draw_bits(2, r);
          wleft  = int'(r);
          fstate = 1;
        end
        if (fstate == 1)
        begin
          if (wleft == 0)
          begin
            // Accepted at the coming rising edge
            flash_waitrequest = 1'b0;
            acc_addr          = flash_address;
            draw_bits(2, r);
            lat    = 1 + int'(r) % 3;
            fstate = 2;
          end
          else
            wleft = wleft - 1;
        end
      end
    end
  end

  // ====================
  // Failure reporting and checks
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "stopping after the first error");
  endtask

  task automatic report_mismatch(input string what, input int got, input int exp);
    stop_run($sformatf("FAIL at %0t ns: %s got %0d expected %0d", $time, what, got, exp));
  endtask

  task automatic check_sample(input sample_t got, input sample_t exp);
    if (got !== exp)
      report_mismatch($sformatf("sample of word %0d", m_addr), int'(got), int'(exp));
  endtask

  task automatic check_interval(input div_t got, input div_t exp);
    if (got !== exp)
      report_mismatch("cycles between samples", int'(got), int'(exp));
  endtask

  // ====================
  // Reference model of the sample order
  function automatic sample_t expected_sample();
    flash_word_t w;
    w = flash_word(m_addr);
    // Forward plays low then high, backward the other way round
    if (!m_rev)
      return m_half ? w[31:16] : w[15:0];
    else
      return m_half ? w[15:0] : w[31:16];
  endfunction

  task automatic advance_model();
    if (!m_half)
      m_half = 1'b1;
    else
    begin
      m_half = 1'b0;
      if (m_rev)
        m_addr = (m_addr == '0) ? LAST_ADDR : m_addr - 23'd1;
      else
        m_addr = (m_addr == LAST_ADDR) ? '0 : m_addr + 23'd1;
    end
  endtask

  task automatic restart_model();
    m_addr = ref_dir ? LAST_ADDR : '0;
    m_half = 1'b0;
    m_rev  = ref_dir;
  endtask

  // One clock with outputs sampled at the falling edge
  task automatic next_cycle();
    @(negedge CLK_50M);
    cyc        = cyc + 1;
    got_sample = 1'b0;
    if (sample_valid)
    begin
      if (expect_quiet)
        stop_run("sample_valid pulsed while the player should be silent");
      else
      begin
        check_sample(sample, expected_sample());
        advance_model();
        got_sample = 1'b1;
      end
    end
  endtask

  task automatic wait_sample();
    int t;
    t = 0;
    got_sample = 1'b0;
    while (!got_sample && t < SAMPLE_TIMEOUT)
    begin
      next_cycle();
      t = t + 1;
    end
    if (!got_sample)
      stop_run("timed out waiting for sample_valid");
  endtask

  task automatic watch_silence(input int cycles);
    int t;
    expect_quiet = 1'b1;
    for (t = 0; t < cycles; t++)
      next_cycle();
    expect_quiet = 1'b0;
  endtask

  task automatic check_idle();
    int t;
    expect_quiet = 1'b1;
    for (t = 0; t < IDLE_CYCLES; t++)
    begin
      next_cycle();
      if (flash_read)
        stop_run("flash_read went high before any command was given");
    end
    expect_quiet = 1'b0;
  endtask

  // ====================
  // Stimulus table
  task automatic add_step(input logic [1:0] kind, input ascii_t code, input int n,
                          input div_t d, input int quiet);
    step_t s;
    s.kind  = kind;
    s.code  = code;
    s.n     = 8'(n);
    s.div   = d;
    s.quiet = 8'(quiet);
    steps.push_back(s);
  endtask

  task automatic build_table();
    // Forward pass with wrap, then backward from the last word
    add_step(K_KEY, "E", 20, 16'd40, 0);
    add_step(K_KEY, "B", 0, 16'd40, 0);
    add_step(K_KEY, "R", 20, 16'd40, 0);
    // Pause, then play again from the start address
    add_step(K_KEY, "D", 0, 16'd40, 10);
    add_step(K_KEY, "E", 6, 16'd40, 0);
    // Speed steps clamped at the minimum
    add_step(K_UP, 8'h00, 4, 16'd32, 0);
    add_step(K_UP, 8'h00, 4, 16'd24, 0);
    add_step(K_UP, 8'h00, 4, 16'd24, 0);
    add_step(K_SRST, 8'h00, 0, 16'd40, 0);
    add_step(K_DOWN, 8'h00, 4, 16'd48, 0);
    // Lower case and an unknown code
    add_step(K_KEY, "f", 0, 16'd48, 0);
    add_step(K_KEY, "r", 6, 16'd48, 0);
    add_step(K_KEY, "X", 6, 16'd48, 0);
    add_step(K_KEY, "d", 0, 16'd48, 10);
    add_step(K_KEY, "e", 4, 16'd48, 0);
    add_step(K_KEY, "b", 0, 16'd48, 0);
    add_step(K_KEY, "r", 6, 16'd48, 0);
  endtask

  task automatic apply_step(input step_t s);
    logic restart_now;
    int   k;
    int   prev;
    restart_now = 1'b0;
    prev        = 0;
    case (s.kind)
      K_KEY:
      begin
        ascii_code  = s.code;
        ascii_valid = 1'b1;
      end
      K_UP:
        speed_up = 1'b1;
      K_DOWN:
        speed_down = 1'b1;
      default:
        speed_reset = 1'b1;
    endcase
    expect_quiet = 1'b0;
    next_cycle();
    ascii_valid = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    // Samples already under way still belong to the old sequence
    next_cycle();
    if (s.kind == K_KEY)
    begin
      case (s.code)
        "E", "e":
        begin
          restart_now = !ref_play;
          ref_play    = 1'b1;
        end
        "D", "d":
          ref_play = 1'b0;
        "F", "f":
          ref_dir = 1'b0;
        "B", "b":
          ref_dir = 1'b1;
        "R", "r":
          restart_now = 1'b1;
        default:
          ;
      endcase
    end
    if (restart_now)
      restart_model();
    if (s.quiet != 8'd0)
      watch_silence(int'(s.quiet) * int'(s.div));
    for (k = 0; k < int'(s.n); k++)
    begin
      wait_sample();
      // First interval after a change is skipped
      if (k >= 2)
        check_interval(div_t'(cyc - prev), s.div);
      prev = cyc;
    end
  endtask

  // ====================
  initial
  begin : stimulus
    int i;
    rst_n        = 1'b0;
    ascii_code   = '0;
    ascii_valid  = 1'b0;
    speed_up     = 1'b0;
    speed_down   = 1'b0;
    speed_reset  = 1'b0;
    cyc          = 0;
    got_sample   = 1'b0;
    expect_quiet = 1'b0;
    ref_play     = 1'b0;
    ref_dir      = 1'b0;
    m_addr       = '0;
    m_half       = 1'b0;
    m_rev        = 1'b0;
    repeat (8) @(posedge CLK_50M);
    @(negedge CLK_50M);
    rst_n = 1'b1;
    check_idle();
    build_table();
    for (i = 0; i < steps.size(); i++)
      apply_step(steps[i]);
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
